//--- Bender.yml
package:
  name: unibus_adapter

sources:
  - src/unibus_pkg.sv
  - src/pin_demux.sv
  - src/bus_mode_router.sv
  - src/host_regs.sv
  - src/unibus_adapter.sv
  - target: test
    files:
      - test/tb_unibus_adapter.sv

//--- project.f
src/unibus_pkg.sv
src/pin_demux.sv
src/bus_mode_router.sv
src/host_regs.sv
src/unibus_adapter.sv
test/tb_unibus_adapter.sv

//--- src/bus_mode_router.sv
// unibus output selection by mode, manual drive from ctla/ctlb, grant chain pass-through
`timescale 1ns/1ps

module bus_mode_router (
    input  unibus_pkg::reg_word_t ctla,
    input  unibus_pkg::reg_word_t ctlb,
    input  unibus_pkg::grant_t    bg_in,
    input  logic                  npg_in,
    output unibus_pkg::addr_t     a_out,
    output unibus_pkg::data_t     d_out,
    output unibus_pkg::cbus_t     c_out,
    output unibus_pkg::grant_t    bg_out,
    output unibus_pkg::grant_t    br_out,
    output logic                  bbsy_out,
    output logic                  hltrq_out,
    output logic                  init_out,
    output logic                  intr_out,
    output logic                  msyn_out,
    output logic                  npg_out,
    output logic                  npr_out,
    output logic                  pa_out,
    output logic                  pb_out,
    output logic                  sack_out,
    output logic                  ssyn_out
);
    import unibus_pkg::*;

    fm_mode_t mode;

    assign mode = fm_mode_t'(ctla[CTLA_MODE_HI:CTLA_MODE_LO]);

    always_comb begin
        // idle values, zero opens the output transistors
        a_out     = '0;
        d_out     = '0;
        c_out     = '0;
        br_out    = '0;
        bbsy_out  = 1'b0;
        hltrq_out = 1'b0;
        init_out  = 1'b0;
        intr_out  = 1'b0;
        msyn_out  = 1'b0;
        npr_out   = 1'b0;
        pa_out    = 1'b0;
        pb_out    = 1'b0;
        sack_out  = 1'b0;
        ssyn_out  = 1'b0;
        bg_out    = bg_in;                      // behave like a grant jumper card
        npg_out   = npg_in;

        case (mode)
            FM_MAN: begin
                a_out     = ctlb[CTLB_A_HI:CTLB_A_LO];
                bg_out    = ctlb[CTLB_BG_HI:CTLB_BG_LO];
                br_out    = ctlb[CTLB_BR_HI:CTLB_BR_LO];
                c_out     = ctlb[CTLB_C_HI:CTLB_C_LO];
                d_out     = ctla[CTLA_D_HI:CTLA_D_LO];
                bbsy_out  = ctla[CTLA_BBSY];
                hltrq_out = ctla[CTLA_HLTRQ];
                init_out  = ctla[CTLA_INIT];
                intr_out  = ctla[CTLA_INTR];
                msyn_out  = ctla[CTLA_MSYN];
                npg_out   = ctla[CTLA_NPG];
                npr_out   = ctla[CTLA_NPR];
                pa_out    = ctla[CTLA_PA];      // parity lines only in manual
                pb_out    = ctla[CTLA_PB];
                sack_out  = ctla[CTLA_SACK];
                ssyn_out  = ctla[CTLA_SSYN];
            end
            FM_OFF, FM_SIM, FM_REAL: ;          // no local devices to drive the bus
            default: ;
        endcase
    end

endmodule

//--- src/host_regs.sv
// AXI-lite read and write channels, ctla/ctlb registers, readback multiplexer
`timescale 1ns/1ps

module host_regs (
    input  logic                  CLOCK,
    input  logic                  RESET_N,
    input  logic [11:0]           ar_addr,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    output unibus_pkg::reg_word_t r_data,
    output logic [1:0]            r_resp,
    output logic                  r_valid,
    input  logic                  r_ready,
    input  logic [11:0]           aw_addr,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  unibus_pkg::reg_word_t w_data,
    input  logic                  w_valid,
    output logic                  w_ready,
    output logic [1:0]            b_resp,
    output logic                  b_valid,
    input  logic                  b_ready,
    input  logic                  rsel1,
    input  logic                  rsel2,
    input  logic                  rsel3,
    input  unibus_pkg::addr_t     dmx_a,
    input  unibus_pkg::data_t     dmx_d,
    input  unibus_pkg::cbus_t     dmx_c,
    input  unibus_pkg::grant_t    dmx_br,
    input  logic                  dmx_npr,
    input  logic                  dmx_pa,
    input  logic                  dmx_pb,
    input  logic                  dmx_hltrq,
    input  logic [9:0]            syn_ctl,
    input  unibus_pkg::grant_t    syn_bg,
    input  logic                  msyn_delayed,
    input  logic [14:0]           mux_pins,
    output unibus_pkg::reg_word_t ctla,
    output unibus_pkg::reg_word_t ctlb
);
    import unibus_pkg::*;

    reg_index_t rd_index, wr_index;
    logic       wr_fire;

    assign r_resp  = 2'b00;                     // always OKAY
    assign b_resp  = 2'b00;
    assign wr_fire = w_valid & w_ready;

    //////////////////////////////
    // read channel
    //////////////////////////////
    always_ff @(posedge CLOCK) begin
        if (!RESET_N) begin
            ar_ready <= 1'b1;
            r_valid  <= 1'b0;
        end else if (ar_valid && ar_ready) begin
            rd_index <= ar_addr[11:2];
            ar_ready <= 1'b0;
            r_valid  <= 1'b1;
        end else if (r_valid && r_ready) begin
            ar_ready <= 1'b1;
            r_valid  <= 1'b0;
        end
    end

    always_comb begin
        case (rd_index)
            REG_VERSION: r_data = ADAPTER_VERSION;
            REG_CTLA:    r_data = ctla;
            REG_CTLB:    r_data = ctlb;
            REG_PINS:    r_data = {mux_pins, rsel1, rsel2, rsel3, syn_ctl, syn_bg};
            REG_DMXA:    r_data = {14'd0, dmx_a};
            REG_DMXD:    r_data = {msyn_delayed, dmx_npr, dmx_pa, dmx_pb, dmx_hltrq,
                                   dmx_br, dmx_c, 5'd0, dmx_d};
            default:     r_data = BAD_READ;
        endcase
    end

    //////////////////////////////
    // write channel
    //////////////////////////////
    always_ff @(posedge CLOCK) begin
        if (!RESET_N) begin
            aw_ready <= 1'b1;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            ctla     <= '0;                     // mode comes up off
        end else if (wr_fire) begin
            if (wr_index == REG_CTLA)
                ctla <= w_data;
            aw_ready <= 1'b1;
            w_ready  <= 1'b0;
            b_valid  <= 1'b1;
        end else begin
            if (aw_valid && aw_ready) begin
                wr_index <= aw_addr[11:2];
                aw_ready <= 1'b0;
                w_ready  <= 1'b1;
            end
            if (b_valid && b_ready)
                b_valid <= 1'b0;
        end
    end

    // ctlb only matters once the host selects manual mode
    always_ff @(posedge CLOCK) begin
        if (wr_fire && wr_index == REG_CTLB)
            ctlb <= w_data;
    end

endmodule

//--- src/pin_demux.sv
// row selector sequencer, multiplexed pin latches, control input synchronizers, delayed msyn
`timescale 1ns/1ps

module pin_demux (
    input  logic                  CLOCK,
    input  logic                  RESET_N,
    input  unibus_pkg::reg_word_t ctla,
    input  unibus_pkg::reg_word_t ctlb,
    input  logic [14:0]           mux_pins,     // pin a in bit 14 down to pin s in bit 0
    input  logic                  ac_lo_in,
    input  logic                  bbsy_in,
    input  logic                  dc_lo_in,
    input  logic                  hltgr_in,
    input  logic                  init_in,
    input  logic                  intr_in,
    input  logic                  msyn_in,
    input  logic                  npg_in,
    input  logic                  sack_in,
    input  logic                  ssyn_in,
    input  unibus_pkg::grant_t    bg_in,
    output logic                  rsel1,
    output logic                  rsel2,
    output logic                  rsel3,
    output unibus_pkg::addr_t     dmx_a,
    output unibus_pkg::data_t     dmx_d,
    output unibus_pkg::cbus_t     dmx_c,
    output unibus_pkg::grant_t    dmx_br,
    output logic                  dmx_npr,
    output logic                  dmx_pa,
    output logic                  dmx_pb,
    output logic                  dmx_hltrq,
    output logic [9:0]            syn_ctl,
    output unibus_pkg::grant_t    syn_bg,
    output logic                  msyn_delayed
);
    import unibus_pkg::*;

    fm_mode_t mode;
    row_sel_t forced_row, row, next_row;
    logic [SOAK_W-1:0] soak;
    logic soak_done;

    assign mode       = fm_mode_t'(ctla[CTLA_MODE_HI:CTLA_MODE_LO]);
    assign forced_row = ctlb[CTLB_ROW_HI:CTLB_ROW_LO];
    assign soak_done  = (soak == SOAK_W'(MUX_SOAK - 1));

    assign rsel1 = (row == 2'd1);
    assign rsel2 = (row == 2'd2);
    assign rsel3 = (row == 2'd3);

    //////////////////////////////
    // row selector sequencing
    //////////////////////////////
    always_comb begin
        if (mode == FM_MAN && forced_row != 2'd0)
            next_row = forced_row;              // host pins one row
        else if (row == 2'd3)
            next_row = 2'd1;
        else
            next_row = row + 2'd1;
    end

    always_ff @(posedge CLOCK) begin
        if (!RESET_N) begin
            row  <= 2'd1;
            soak <= '0;
        end else if (soak_done) begin
            row  <= next_row;
            soak <= '0;
        end else begin
            soak <= soak + 1'b1;                // let the selector transistors settle
        end
    end

    // one name per mux pin
    logic muxa, muxb, muxc, muxd, muxe, muxf, muxh, muxj;
    logic muxk, muxl, muxm, muxn, muxp, muxr, muxs;

    assign {muxa, muxb, muxc, muxd, muxe, muxf, muxh, muxj} = mux_pins[14:7];
    assign {muxk, muxl, muxm, muxn, muxp, muxr, muxs}       = mux_pins[6:0];

    // scatter the soaked row into the field latches
    always_ff @(posedge CLOCK) begin
        if (soak_done) begin
            case (row)
                2'd1: begin
                    dmx_pa    <= muxa;
                    dmx_d[11] <= muxb;
                    dmx_hltrq <= muxc;
                    dmx_pb    <= muxd;
                    dmx_d[15] <= muxe;
                    dmx_d[14] <= muxf;
                    dmx_d[13] <= muxh;
                    dmx_d[12] <= muxj;
                    dmx_d[10] <= muxk;
                    dmx_d[9]  <= muxl;
                    dmx_d[8]  <= muxm;
                    dmx_d[7]  <= muxn;
                    dmx_d[4]  <= muxp;
                    dmx_d[5]  <= muxr;
                    dmx_d[1]  <= muxs;
                end
                2'd2: begin                     // pin s unused on this row
                    dmx_a[12]  <= muxa;
                    dmx_a[17]  <= muxb;
                    dmx_a[2]   <= muxc;
                    dmx_d[0]   <= muxd;
                    dmx_d[3]   <= muxe;
                    dmx_d[2]   <= muxf;
                    dmx_d[6]   <= muxh;
                    dmx_br[3]  <= muxj;         // br7
                    dmx_br[2]  <= muxk;
                    dmx_br[1]  <= muxl;
                    dmx_br[0]  <= muxm;         // br4
                    dmx_a[15]  <= muxn;
                    dmx_a[16]  <= muxp;
                    dmx_c[1]   <= muxr;
                end
                2'd3: begin
                    dmx_a[1]   <= muxa;
                    dmx_a[14]  <= muxb;
                    dmx_a[11]  <= muxc;
                    dmx_a[10]  <= muxd;
                    dmx_a[9]   <= muxe;
                    dmx_a[6]   <= muxf;
                    dmx_a[5]   <= muxh;
                    dmx_npr    <= muxj;
                    dmx_a[0]   <= muxk;
                    dmx_c[0]   <= muxl;
                    dmx_a[13]  <= muxm;
                    dmx_a[8]   <= muxn;
                    dmx_a[7]   <= muxp;
                    dmx_a[4]   <= muxr;
                    dmx_a[3]   <= muxs;
                end
                default: ;
            endcase
        end
    end

    //////////////////////////////
    // half rate synchronizers
    //////////////////////////////
    logic sync_phase;
    logic [SYN_WIDTH-1:0] sync_in, sync_mid, sync_out;

    assign sync_in = {ac_lo_in, bbsy_in, dc_lo_in, hltgr_in, init_in,
                      intr_in, msyn_in, npg_in, sack_in, ssyn_in, bg_in};

    always_ff @(posedge CLOCK) begin
        if (!RESET_N)
            sync_phase <= 1'b0;
        else
            sync_phase <= ~sync_phase;
    end

    for (genvar i = 0; i < SYN_WIDTH; i++) begin : g_sync
        always_ff @(posedge CLOCK) begin
            if (!RESET_N) begin
                sync_mid[i] <= 1'b0;
                sync_out[i] <= 1'b0;
            end else if (sync_phase) begin
                sync_mid[i] <= sync_in[i];      // first stage on odd clocks
            end else begin
                sync_out[i] <= sync_mid[i];
            end
        end
    end

    assign syn_ctl = sync_out[SYN_WIDTH-1:4];
    assign syn_bg  = sync_out[3:0];

    // msyn held back until every row has been refreshed
    logic [DLY_W-1:0] msyn_cnt;

    always_ff @(posedge CLOCK) begin
        if (!RESET_N || !syn_ctl[SYN_MSYN]) begin
            msyn_delayed <= 1'b0;
            msyn_cnt     <= '0;
        end else if (msyn_cnt != DLY_W'(MSYN_DELAY - 1)) begin
            msyn_cnt <= msyn_cnt + 1'b1;
        end else begin
            msyn_delayed <= 1'b1;
        end
    end

endmodule

//--- src/unibus_adapter.sv
// unibus pin adapter top level wiring demux, mode router and host registers
`timescale 1ns/1ps

module unibus_adapter (
    input  logic                  CLOCK,
    input  logic                  RESET_N,
    input  logic [14:0]           mux_pins,
    output logic                  rsel1,
    output logic                  rsel2,
    output logic                  rsel3,
    input  logic                  ac_lo_in,
    input  logic                  bbsy_in,
    input  logic                  dc_lo_in,
    input  logic                  hltgr_in,
    input  logic                  init_in,
    input  logic                  intr_in,
    input  logic                  msyn_in,
    input  logic                  npg_in,
    input  logic                  sack_in,
    input  logic                  ssyn_in,
    input  unibus_pkg::grant_t    bg_in,
    output unibus_pkg::addr_t     a_out,
    output unibus_pkg::data_t     d_out,
    output unibus_pkg::cbus_t     c_out,
    output unibus_pkg::grant_t    bg_out,
    output unibus_pkg::grant_t    br_out,
    output logic                  bbsy_out,
    output logic                  hltrq_out,
    output logic                  init_out,
    output logic                  intr_out,
    output logic                  msyn_out,
    output logic                  npg_out,
    output logic                  npr_out,
    output logic                  pa_out,
    output logic                  pb_out,
    output logic                  sack_out,
    output logic                  ssyn_out,
    input  logic [11:0]           ar_addr,
    input  logic                  ar_valid,
    output logic                  ar_ready,
    output unibus_pkg::reg_word_t r_data,
    output logic [1:0]            r_resp,
    output logic                  r_valid,
    input  logic                  r_ready,
    input  logic [11:0]           aw_addr,
    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  unibus_pkg::reg_word_t w_data,
    input  logic                  w_valid,
    output logic                  w_ready,
    output logic [1:0]            b_resp,
    output logic                  b_valid,
    input  logic                  b_ready
);
    import unibus_pkg::*;

    reg_word_t ctla, ctlb;
    addr_t     dmx_a;
    data_t     dmx_d;
    cbus_t     dmx_c;
    grant_t    dmx_br, syn_bg;
    logic      dmx_npr, dmx_pa, dmx_pb, dmx_hltrq, msyn_delayed;
    logic [9:0] syn_ctl;

    pin_demux u_demux (
        .CLOCK, .RESET_N, .ctla, .ctlb, .mux_pins,
        .ac_lo_in, .bbsy_in, .dc_lo_in, .hltgr_in, .init_in,
        .intr_in, .msyn_in, .npg_in, .sack_in, .ssyn_in, .bg_in,
        .rsel1, .rsel2, .rsel3,
        .dmx_a, .dmx_d, .dmx_c, .dmx_br, .dmx_npr, .dmx_pa, .dmx_pb, .dmx_hltrq,
        .syn_ctl, .syn_bg, .msyn_delayed
    );

    bus_mode_router u_router (
        .ctla, .ctlb, .bg_in, .npg_in,
        .a_out, .d_out, .c_out, .bg_out, .br_out,
        .bbsy_out, .hltrq_out, .init_out, .intr_out, .msyn_out, .npg_out,
        .npr_out, .pa_out, .pb_out, .sack_out, .ssyn_out
    );

    host_regs u_regs (
        .CLOCK, .RESET_N,
        .ar_addr, .ar_valid, .ar_ready, .r_data, .r_resp, .r_valid, .r_ready,
        .aw_addr, .aw_valid, .aw_ready, .w_data, .w_valid, .w_ready,
        .b_resp, .b_valid, .b_ready,
        .rsel1, .rsel2, .rsel3,
        .dmx_a, .dmx_d, .dmx_c, .dmx_br, .dmx_npr, .dmx_pa, .dmx_pb, .dmx_hltrq,
        .syn_ctl, .syn_bg, .msyn_delayed, .mux_pins,
        .ctla, .ctlb
    );

endmodule

//--- src/unibus_pkg.sv
// unibus widths, mode encoding, register map, ctla/ctlb field positions, demux constants
package unibus_pkg;

    typedef logic [17:0] addr_t;
    typedef logic [15:0] data_t;
    typedef logic [1:0]  cbus_t;
    typedef logic [3:0]  grant_t;       // levels 7 down to 4
    typedef logic [31:0] reg_word_t;
    typedef logic [9:0]  reg_index_t;   // host address bits 11:2
    typedef logic [1:0]  row_sel_t;     // 0 selects no row

    typedef enum logic [1:0] {
        FM_OFF  = 2'd0,
        FM_SIM  = 2'd1,                 // no simulator path, acts like off
        FM_REAL = 2'd2,
        FM_MAN  = 2'd3
    } fm_mode_t;

    //////////////////////////////
    // demux and synchronizer timing
    //////////////////////////////
    localparam int MUX_SOAK   = 5;                  // clocks a row is held before latching
    localparam int MSYN_DELAY = MUX_SOAK * 3;       // one full scan of all rows
    localparam int SOAK_W     = $clog2(MUX_SOAK);
    localparam int DLY_W      = $clog2(MSYN_DELAY);
    localparam int SYN_WIDTH  = 14;                 // ten control lines plus four grants
    localparam int SYN_MSYN   = 3;                  // msyn position within syn_ctl

    localparam reg_word_t ADAPTER_VERSION = 32'h31314004;
    localparam reg_word_t BAD_READ        = 32'hDEADBEEF;

    // host word addresses
    localparam reg_index_t REG_VERSION = 10'd0;
    localparam reg_index_t REG_CTLA    = 10'd1;
    localparam reg_index_t REG_CTLB    = 10'd2;
    localparam reg_index_t REG_PINS    = 10'd3;
    localparam reg_index_t REG_DMXA    = 10'd4;
    localparam reg_index_t REG_DMXD    = 10'd5;

    // ctla layout
    localparam int CTLA_MODE_HI = 31;
    localparam int CTLA_MODE_LO = 30;
    localparam int CTLA_BBSY    = 26;
    localparam int CTLA_HLTRQ   = 25;
    localparam int CTLA_INIT    = 24;
    localparam int CTLA_INTR    = 23;
    localparam int CTLA_MSYN    = 22;
    localparam int CTLA_NPG     = 21;
    localparam int CTLA_NPR     = 20;
    localparam int CTLA_PA      = 19;
    localparam int CTLA_PB      = 18;
    localparam int CTLA_SACK    = 17;
    localparam int CTLA_SSYN    = 16;
    localparam int CTLA_D_HI    = 15;
    localparam int CTLA_D_LO    = 0;

    // ctlb layout
    localparam int CTLB_ROW_HI  = 29;
    localparam int CTLB_ROW_LO  = 28;
    localparam int CTLB_BG_HI   = 27;
    localparam int CTLB_BG_LO   = 24;
    localparam int CTLB_BR_HI   = 23;
    localparam int CTLB_BR_LO   = 20;
    localparam int CTLB_C_HI    = 19;
    localparam int CTLB_C_LO    = 18;
    localparam int CTLB_A_HI    = 17;
    localparam int CTLB_A_LO    = 0;

endpackage

//--- test/tb_unibus_adapter.sv
// testbench: clock, reset, AXI-lite tasks, mux pin emulator, stim file driven checks, report
`timescale 1ns/1ps

module tb_unibus_adapter;

    localparam int MAX_STEPS = 64;

    logic        CLOCK;
    logic        RESET_N;
    logic [14:0] mux_pins = '0;
    logic        rsel1, rsel2, rsel3;
    logic        ac_lo_in, bbsy_in, dc_lo_in, hltgr_in, init_in;
    logic        intr_in, msyn_in, npg_in, sack_in, ssyn_in;
    logic [3:0]  bg_in;
    logic [17:0] a_out;
    logic [15:0] d_out;
    logic [1:0]  c_out;
    logic [3:0]  bg_out, br_out;
    logic        bbsy_out, hltrq_out, init_out, intr_out, msyn_out, npg_out;
    logic        npr_out, pa_out, pb_out, sack_out, ssyn_out;
    logic [11:0] ar_addr, aw_addr;
    logic        ar_valid, ar_ready, r_valid, r_ready;
    logic [31:0] r_data, w_data;
    logic [1:0]  r_resp, b_resp;
    logic        aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;

    // stimulus table
    logic [63:0] step_op [0:MAX_STEPS-1];
    logic [31:0] step_f  [0:MAX_STEPS-1][0:4];
    int          n_steps = 0;
    int          step    = 0;

    // field values the emulated bus presents on the mux pins
    logic [17:0] pin_a  = '0;
    logic [15:0] pin_d  = '0;
    logic [1:0]  pin_c  = '0;
    logic [3:0]  pin_br = '0;

    logic [31:0] sh_ctla = '0;                  // last value the host wrote
    logic [31:0] sh_ctlb = '0;
    integer      seed = 32'h1594_2826;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          cycle_limit = 100;

    unibus_adapter UUT (.*);

    initial begin
        CLOCK = 1'b0;
        forever #20 CLOCK = ~CLOCK;
    end

    //////////////////////////////
    // mux pin emulation
    //////////////////////////////
    // pin order a b c d e f h j k l m n p r s, msb first
    function automatic logic [14:0] encode_pins(input logic [2:0] sel, input logic [17:0] a,
                                                input logic [15:0] d, input logic [1:0] c,
                                                input logic [3:0] br);
        case (sel)
            3'b100:  return {1'b0, d[11], 1'b0, 1'b0, d[15], d[14], d[13], d[12],
                             d[10], d[9], d[8], d[7], d[4], d[5], d[1]};
            3'b010:  return {a[12], a[17], a[2], d[0], d[3], d[2], d[6], br[3],
                             br[2], br[1], br[0], a[15], a[16], c[1], 1'b0};
            3'b001:  return {a[1], a[14], a[11], a[10], a[9], a[6], a[5], 1'b0,
                             a[0], c[0], a[13], a[8], a[7], a[4], a[3]};
            default: return 15'd0;              // no row selected
        endcase
    endfunction

    always @(posedge CLOCK) begin
        mux_pins <= encode_pins({rsel1, rsel2, rsel3}, pin_a, pin_d, pin_c, pin_br);
    end

    always @(posedge CLOCK) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic compare_word(input string what, input logic [31:0] expected,
                                input logic [31:0] seen, input logic [31:0] mask);
        checks++;
        assert ((seen & mask) === (expected & mask)) else begin
            errors++;
            $display("** Error at %0t ns: step %0d, %s expected %h, seen %h",
                     $time, step, what, expected & mask, seen & mask);
        end
    endtask

    //////////////////////////////
    // AXI-lite host tasks
    //////////////////////////////
    task automatic axi_write(input logic [9:0] index, input logic [31:0] data);
        @(posedge CLOCK);
        aw_addr  <= {index, 2'b00};
        aw_valid <= 1'b1;
        do @(posedge CLOCK); while (!aw_ready);   // ready seen before this edge
        aw_valid <= 1'b0;
        w_data   <= data;
        w_valid  <= 1'b1;
        do @(posedge CLOCK); while (!w_ready);
        w_valid  <= 1'b0;
        b_ready  <= 1'b1;
        do @(posedge CLOCK); while (!b_valid);
        compare_word("b_resp", 32'd0, b_resp, 32'h3);
        b_ready  <= 1'b0;
    endtask

    task automatic axi_read(input logic [9:0] index, output logic [31:0] data);
        int stall;
        @(posedge CLOCK);
        ar_addr  <= {index, 2'b00};
        ar_valid <= 1'b1;
        do @(posedge CLOCK); while (!ar_ready);
        ar_valid <= 1'b0;
        do @(posedge CLOCK); while (!r_valid);
        stall = $random(seed) & 3;              // back-pressure on the response
        repeat (stall) begin
            @(posedge CLOCK);
            compare_word("r_valid under back-pressure", 32'd1, r_valid, 32'd1);
        end
        r_ready <= 1'b1;
        @(posedge CLOCK);
        data = r_data;
        compare_word("r_resp", 32'd0, r_resp, 32'h3);
        r_ready <= 1'b0;
    endtask

    //////////////////////////////
    // bus output checks
    //////////////////////////////
    task automatic check_bus(input logic [3:0] bg, input logic npg);
        logic        manual;
        logic [10:0] lines;
        @(posedge CLOCK);
        bg_in  <= bg;
        npg_in <= npg;
        @(negedge CLOCK);                       // router output settled
        manual = (sh_ctla[31:30] == 2'b11);
        lines  = manual ? sh_ctla[26:16] : {5'd0, npg, 5'd0};
        compare_word("a_out", manual ? sh_ctlb[17:0] : 18'd0, a_out, 32'h3ffff);
        compare_word("d_out", manual ? sh_ctla[15:0] : 16'd0, d_out, 32'hffff);
        compare_word("c_out", manual ? sh_ctlb[19:18] : 2'd0, c_out, 32'h3);
        compare_word("bg_out", manual ? sh_ctlb[27:24] : bg, bg_out, 32'hf);
        compare_word("br_out", manual ? sh_ctlb[23:20] : 4'd0, br_out, 32'hf);
        compare_word("control lines", lines,
                     {bbsy_out, hltrq_out, init_out, intr_out, msyn_out, npg_out,
                      npr_out, pa_out, pb_out, sack_out, ssyn_out}, 32'h7ff);
    endtask

    task automatic check_rows(input int n);
        repeat (16) begin                       // held through a whole scan
            @(negedge CLOCK);
            compare_word("row selects", 32'd4 >> (n - 1), {rsel1, rsel2, rsel3}, 32'h7);
        end
    endtask

    //////////////////////////////
    // stimulus file
    //////////////////////////////
    task automatic load_stimulus();
        int          fd;
        int          code;
        int          ch;
        int          nf;
        int          k;
        logic [63:0] tok;
        logic [31:0] val;
        fd = $fopen("test/unibus_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file test/unibus_stim.txt");
        end else begin
            while (!$feof(fd) && n_steps < MAX_STEPS) begin
                tok  = '0;
                code = $fscanf(fd, "%s", tok);
                if (code == 1 && tok == "#") begin
                    ch = $fgetc(fd);            // skip the remark line
                    while (ch != "\n" && ch != -1)
                        ch = $fgetc(fd);
                end else if (code == 1) begin
                    step_op[n_steps] = tok;
                    nf = (tok == "PINS") ? 5 : (tok == "R") ? 3 :
                         (tok == "W" || tok == "MAN") ? 2 : 1;
                    for (k = 0; k < nf; k++) begin
                        if (tok == "WAIT")
                            code = $fscanf(fd, "%d", val);
                        else
                            code = $fscanf(fd, "%h", val);
                        step_f[n_steps][k] = val;
                    end
                    n_steps++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = 40 * n_steps + 100;
    endtask

    task automatic run_step(input int i);
        logic [63:0] op;
        logic [31:0] f0, f1, f2, f3, f4;
        logic [31:0] word;
        op = step_op[i];
        f0 = step_f[i][0];
        f1 = step_f[i][1];
        f2 = step_f[i][2];
        f3 = step_f[i][3];
        f4 = step_f[i][4];
        if (op == "W") begin
            axi_write(f0[9:0], f1);
            if (f0 == 32'd1)
                sh_ctla = f1;
            else if (f0 == 32'd2)
                sh_ctlb = f1;                   // other words are ignored
        end else if (op == "R") begin
            axi_read(f0[9:0], word);
            compare_word("register read", f1, word, f2);
        end else if (op == "MAN") begin
            check_bus(f0[3:0], f1[0]);
        end else if (op == "PINS") begin
            @(posedge CLOCK);
            pin_a   <= f0[17:0];
            pin_d   <= f1[15:0];
            pin_c   <= f2[1:0];
            pin_br  <= f3[3:0];
            msyn_in <= f4[0];
        end else if (op == "WAIT") begin
            repeat (f0) @(posedge CLOCK);
        end else if (op == "ROW") begin
            check_rows(f0);
        end else begin
            errors++;
            $display("step %0d has an unknown operation and was skipped", i);
        end
    endtask

    initial begin
        RESET_N  = 1'b0;
        ac_lo_in = 1'b0;
        bbsy_in  = 1'b0;
        dc_lo_in = 1'b0;
        hltgr_in = 1'b0;
        init_in  = 1'b0;
        intr_in  = 1'b0;
        msyn_in  = 1'b0;
        npg_in   = 1'b0;
        sack_in  = 1'b0;
        ssyn_in  = 1'b0;
        bg_in    = 4'd0;
        ar_addr  = 12'd0;
        ar_valid = 1'b0;
        r_ready  = 1'b0;
        aw_addr  = 12'd0;
        aw_valid = 1'b0;
        w_data   = 32'd0;
        w_valid  = 1'b0;
        b_ready  = 1'b0;
        load_stimulus();
        repeat (2) @(posedge CLOCK);
        RESET_N <= 1'b1;
        for (step = 0; step < n_steps; step++)
            run_step(step);
        repeat (4) @(posedge CLOCK);
        $display("steps: %0d, checks: %0d, errors: %0d", n_steps, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

//--- test/unibus_stim.txt
# op and fields in hex, the WAIT count in decimal clocks
# W idx data | R idx expected mask | MAN bg_in npg_in | PINS a d c br msyn | ROW n
R 0 31314004 ffffffff
R 7 deadbeef ffffffff
R 1 00000000 ffffffff
MAN 5 0
MAN a 1
W 1 c5a5f00d
W 2 0a9bcdef
R 1 c5a5f00d ffffffff
R 2 0a9bcdef ffffffff
MAN 3 1
W 3 12345678
R 1 c5a5f00d ffffffff
R 2 0a9bcdef ffffffff
R 0 31314004 ffffffff
W 1 3a5a0ff2
MAN 6 1
W 1 80000000
PINS 2a5c3 b6e1 2 9 1
WAIT 40
R 4 0002a5c3 ffffffff
R 5 84c0b6e1 ffffffff
PINS 2a5c3 b6e1 2 9 0
WAIT 10
R 5 04c0b6e1 ffffffff
PINS 15a3c 4d1e 1 6 0
WAIT 40
R 4 00015a3c ffffffff
R 5 03204d1e ffffffff
W 2 2a9bcdef
W 1 c5a5f00d
WAIT 40
ROW 2
R 3 00008000 0001c000
MAN 0 0
